// ==== design/mbWordIf.sv ====
// Interface for pending words, kind flags and word clear commands
`timescale 1ns/1ps

interface mbWordIf;
  import mbxPkg::*;

  // Tracker side
  wordMaskT pending;
  logic     isWriteback;
  logic     isWrite;

  // Arbiter side with a one-cycle clear strobe
  logic     clearEn;
  wordIdxT  clearWord;

  modport tracker (
    output pending,
    output isWriteback,
    output isWrite,
    input  clearEn,
    input  clearWord
  );

  modport arbiter (
    input  pending,
    input  isWriteback,
    input  isWrite,
    output clearEn,
    output clearWord
  );

  // Read-only view for the writeback phase machine
  modport sequencer (
    input  pending,
    input  isWriteback
  );

endinterface

// ==== design/mbxControl.sv ====
// MB word request control top level with tracker, writeback sequencer and request arbiter
`timescale 1ns/1ps

module mbxControl (
  input  logic              clk,
  input  logic              rst,
  input  logic              startCycle,
  input  mbxPkg::cycleKindT cycleKind,
  input  mbxPkg::wordIdxT   wordAddr,
  input  mbxPkg::wordMaskT  wordValid,
  input  mbxPkg::wordMaskT  wordNeeded,
  input  logic              ackPulse,
  input  logic              phaseChangeComing,
  output mbxPkg::wordMaskT  pendingWords,
  output mbxPkg::wordIdxT   sbusWord,
  output logic              memRdRq,
  output logic              memWrRq,
  output logic              cacheToMbDone
);

  // Word moved pulse and continuation level between sequencer and arbiter
  logic wordMoved;
  logic moreWords;

  mbWordIf words ();

  wordRequestTracker i_tracker (
    .clk        (clk),
    .rst        (rst),
    .startCycle (startCycle),
    .cycleKind  (cycleKind),
    .wordAddr   (wordAddr),
    .wordValid  (wordValid),
    .wordNeeded (wordNeeded),
    .words      (words.tracker)
  );

  writebackSequencer i_sequencer (
    .clk               (clk),
    .rst               (rst),
    .phaseChangeComing (phaseChangeComing),
    .moreWords         (moreWords),
    .words             (words.sequencer),
    .wordMoved         (wordMoved),
    .cacheToMbDone     (cacheToMbDone)
  );

  memRequestArbiter i_arbiter (
    .ackPulse  (ackPulse),
    .wordMoved (wordMoved),
    .words     (words.arbiter),
    .moreWords (moreWords),
    .sbusWord  (sbusWord),
    .memRdRq   (memRdRq),
    .memWrRq   (memWrRq)
  );

  assign pendingWords = words.pending;

endmodule

// ==== design/mbxPkg.sv ====
// Memory buffer word constants, word mask and index types, cycle kind and sequencer state enums
package mbxPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Buffer geometry
  ////////////////////////////////////////////////////////////////////////////

  // Words held in the memory buffer
  localparam int NumWords = 4;

  // Bits needed to address one buffer word
  localparam int WordIdxW = 2;

  // One bit per buffer word with bit 0 for word 0
  typedef logic [NumWords-1:0] wordMaskT;

  // Index of a single buffer word
  typedef logic [WordIdxW-1:0] wordIdxT;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Kind of memory buffer cycle presented with the start strobe
  typedef enum logic [2:0] {
    kindIdle        = 3'd0,
    kindCoreRead    = 3'd1,
    kindOneWordRead = 3'd2,
    kindPageRefill  = 3'd3,
    kindChanWrite   = 3'd4,
    kindWriteback   = 3'd5
  } cycleKindT;

  // Cache to MB phase machine
  typedef enum logic [2:0] {
    seqIdle = 3'd0,
    seqT1   = 3'd1,
    seqT2   = 3'd2,
    seqT3   = 3'd3,
    seqT4   = 3'd4
  } seqStateT;

endpackage

// ==== design/memRequestArbiter.sv ====
// Priority word select, memory read and write request levels and word clear control
`timescale 1ns/1ps

module memRequestArbiter (
  input  logic            ackPulse,
  input  logic            wordMoved,
  mbWordIf.arbiter        words,
  output logic            moreWords,
  output mbxPkg::wordIdxT sbusWord,
  output logic            memRdRq,
  output logic            memWrRq
);
  import mbxPkg::*;

  wordIdxT  selWord;
  wordMaskT selMask;
  logic     anyPending;

  ////////////////////////////////////////////////////////////////////////////
  // Priority encoder, word 0 first
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    selWord = '0;
    // Scan downward so the lowest set index wins
    for (int i = NumWords - 1; i >= 0; i--) begin
      if (words.pending[i]) begin
        selWord = wordIdxT'(i);
      end
    end
  end

  assign selMask    = wordMaskT'(1) << selWord;
  assign anyPending = (words.pending != '0);
  assign moreWords  = ((words.pending & ~selMask) != '0);
  assign sbusWord   = selWord;

  ////////////////////////////////////////////////////////////////////////////
  // Request levels
  ////////////////////////////////////////////////////////////////////////////

  assign memRdRq = anyPending && !words.isWrite;

  // Writeback requests only while the sequencer is in T4
  assign memWrRq = words.isWrite &&
                   (words.isWriteback ? wordMoved : anyPending);

  // Clear source depends on the cycle kind
  // ackPulse is dropped in writeback and on an empty mask
  assign words.clearEn   = words.isWriteback ? wordMoved : (ackPulse && anyPending);
  assign words.clearWord = selWord;

endmodule

// ==== design/wordRequestTracker.sv ====
// Pending word mask register with cycle kind flags, loaded at start and cleared per word
`timescale 1ns/1ps

module wordRequestTracker (
  input  logic              clk,
  input  logic              rst,
  input  logic              startCycle,
  input  mbxPkg::cycleKindT cycleKind,
  input  mbxPkg::wordIdxT   wordAddr,
  input  mbxPkg::wordMaskT  wordValid,
  input  mbxPkg::wordMaskT  wordNeeded,
  mbWordIf.tracker          words
);
  import mbxPkg::*;

  wordMaskT pending;
  wordMaskT loadMask;
  wordMaskT clearMask;
  logic     isWrite;
  logic     isWriteback;
  logic     loadWrite;
  logic     loadWriteback;

  ////////////////////////////////////////////////////////////////////////////
  // Load decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    loadMask      = '0;
    loadWrite     = 1'b0;
    loadWriteback = 1'b0;
    case (cycleKind)
      kindOneWordRead: loadMask = wordMaskT'(1) << wordAddr;
      // Only the words the cache does not already hold
      kindCoreRead,
      kindPageRefill:  loadMask = wordNeeded & ~wordValid;
      kindChanWrite: begin
        loadMask  = wordNeeded;
        loadWrite = 1'b1;
      end
      kindWriteback: begin
        loadMask      = wordNeeded;
        loadWrite     = 1'b1;
        loadWriteback = 1'b1;
      end
      default:         loadMask = '0;
    endcase
  end

  // Single word dropped by the arbiter
  assign clearMask = words.clearEn ? (wordMaskT'(1) << words.clearWord) : '0;

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      pending     <= '0;
      isWrite     <= 1'b0;
      isWriteback <= 1'b0;
    end else if (startCycle) begin
      // A new cycle wins over a clear in the same cycle
      pending     <= loadMask;
      isWrite     <= loadWrite;
      isWriteback <= loadWriteback;
    end else begin
      pending <= pending & ~clearMask;
    end
  end

  assign words.pending     = pending;
  assign words.isWrite     = isWrite;
  assign words.isWriteback = isWriteback;

endmodule

// ==== design/writebackSequencer.sv ====
// Cache to MB writeback phase machine T1 to T4 with word moved and done pulses
`timescale 1ns/1ps

module writebackSequencer (
  input  logic        clk,
  input  logic        rst,
  input  logic        phaseChangeComing,
  input  logic        moreWords,
  mbWordIf.sequencer  words,
  output logic        wordMoved,
  output logic        cacheToMbDone
);
  import mbxPkg::*;

  seqStateT state;
  seqStateT stateNext;
  logic     startWb;
  // Set in T4 when the word just moved was the last one
  logic     noContinue;

  assign startWb = words.isWriteback && (words.pending != '0);

  always_comb begin
    stateNext = state;
    case (state)
      seqIdle: begin
        if (startWb) begin
          stateNext = seqT1;
        end
      end
      seqT1: begin
        if (noContinue) begin
          stateNext = seqIdle;
        end else begin
          stateNext = seqT2;
        end
      end
      // Hold here until the memory phase is about to change
      seqT2: begin
        if (phaseChangeComing) begin
          stateNext = seqT3;
        end
      end
      seqT3:   stateNext = seqT4;
      seqT4:   stateNext = seqT1;
      default: stateNext = seqIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= seqIdle;
      noContinue <= 1'b0;
    end else begin
      state <= stateNext;
      if (state == seqIdle) begin
        noContinue <= 1'b0;
      end else if (state == seqT4) begin
        noContinue <= ~moreWords;
      end
    end
  end

  // One transfer per T4
  assign wordMoved     = (state == seqT4);
  assign cacheToMbDone = (state == seqT1) && noContinue;

endmodule

// ==== filelist.f ====
design/mbxPkg.sv
design/mbWordIf.sv
design/wordRequestTracker.sv
design/writebackSequencer.sv
design/memRequestArbiter.sv
design/mbxControl.sv
test/mbxChecker.sv
test/mbxControlTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f filelist.f --top-module mbxControlTb -o mbxSim || exit 1
out=$(./obj_dir/mbxSim)
echo "$out"
echo "$out" | grep -q "RESULT: PASS" && exit 0 || exit 1

// ==== test/mbxChecker.sv ====
// Reference model of the word request rules, output comparisons and per-test reporting
`timescale 1ns/1ps

module mbxChecker (
  input  logic              clk,
  input  logic              rst,
  input  logic              startCycle,
  input  mbxPkg::cycleKindT cycleKind,
  input  mbxPkg::wordIdxT   wordAddr,
  input  mbxPkg::wordMaskT  wordValid,
  input  mbxPkg::wordMaskT  wordNeeded,
  input  logic              ackPulse,
  input  logic              phaseChangeComing,
  input  mbxPkg::wordMaskT  pendingWords,
  input  mbxPkg::wordIdxT   sbusWord,
  input  logic              memRdRq,
  input  logic              memWrRq,
  input  logic              cacheToMbDone,
  output int                errCount
);
  import mbxPkg::*;

  wordMaskT expPending;
  wordMaskT loaded;
  seqStateT expSeq;
  logic     expWrite;
  logic     expWb;
  logic     expWrRq;
  logic     clearNow;
  logic     armed = 1'b0;
  int       errTotal = 0;
  int       testErrs = 0;
  int       wrPulses = 0;
  int       donePulses = 0;
  int       testCount = 0;
  int       failedTests = 0;

  assign errCount = errTotal;

  function automatic int lowestIdx(input wordMaskT m);
    for (int i = 0; i < NumWords; i++) begin
      if (m[i]) return i;
    end
    return 0;
  endfunction

  function automatic wordMaskT loadRule(input cycleKindT k, input wordIdxT a,
                                        input wordMaskT v, input wordMaskT n);
    wordMaskT m;
    m = '0;
    case (k)
      kindOneWordRead: m[a] = 1'b1;
      kindCoreRead, kindPageRefill: m = n & ~v;
      kindChanWrite, kindWriteback: m = n;
      default: m = '0;
    endcase
    return m;
  endfunction

  task automatic reportProblem(input string msg);
    $display("%s at %0t", msg, $time);
    errTotal++;
    testErrs++;
  endtask

  task automatic compareValue(input string sig, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h at %0t", sig, got, exp, $time);
      errTotal++;
      testErrs++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Model update on the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      expPending = '0;
      expWrite   = 1'b0;
      expWb      = 1'b0;
      expSeq     = seqIdle;
      armed      = 1'b1;
    end else begin
      // Writeback words leave in T4 and other kinds on an ack while words remain
      clearNow = expWb ? (expSeq == seqT4) : (ackPulse && expPending != '0);
      // Phase machine step from the values before this edge
      case (expSeq)
        seqIdle: begin
          if (expWb && expPending != '0) begin
            expSeq = seqT1;
          end
        end
        seqT1:   expSeq = (expPending == '0) ? seqIdle : seqT2;
        seqT2: begin
          if (phaseChangeComing) begin
            expSeq = seqT3;
          end
        end
        seqT3:   expSeq = seqT4;
        seqT4:   expSeq = seqT1;
        default: expSeq = seqIdle;
      endcase
      if (startCycle) begin
        expPending = loadRule(cycleKind, wordAddr, wordValid, wordNeeded);
        expWrite   = (cycleKind == kindChanWrite) || (cycleKind == kindWriteback);
        expWb      = (cycleKind == kindWriteback);
        loaded     = expPending;
      end else if (clearNow) begin
        // The selected word is always the lowest pending one
        expPending[lowestIdx(expPending)] = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output comparisons on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (armed) begin
      expWrRq = (expWb && expSeq == seqT4) || (expWrite && !expWb && expPending != '0);
      compareValue("pendingWords", 32'(pendingWords), 32'(expPending));
      compareValue("sbusWord", 32'(sbusWord), 32'(lowestIdx(expPending)));
      compareValue("memRdRq", 32'(memRdRq), 32'(expPending != '0 && !expWrite));
      compareValue("memWrRq", 32'(memWrRq), 32'(expWrRq));
      // Done comes in the T1 that finds no word left
      compareValue("cacheToMbDone", 32'(cacheToMbDone),
                   32'(expSeq == seqT1 && expPending == '0));
      if (expWb && memWrRq) begin
        wrPulses++;
      end
      if (cacheToMbDone) donePulses++;
    end
  end

  task automatic finishTest(input string name);
    if (expWb && wrPulses != $countones(loaded)) begin
      reportProblem($sformatf("writeback moved %0d words but %0d were loaded",
                              wrPulses, $countones(loaded)));
    end
    if (expWb && donePulses != ((loaded != '0) ? 1 : 0)) begin
      reportProblem($sformatf("writeback done pulsed %0d times", donePulses));
    end
    testCount++;
    if (testErrs == 0) begin
      $display("test %0d %s: ok", testCount, name);
    end else begin
      failedTests++;
      $display("test %0d %s: %0d errors", testCount, name, testErrs);
    end
    testErrs   = 0;
    wrPulses   = 0;
    donePulses = 0;
  endtask

  task automatic reportTotals();
    $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errTotal);
  endtask

endmodule

// ==== test/mbxControlTb.sv ====
// Testbench top with clock, reset, stimulus table, drive loop and watchdog
`timescale 1ns/1ps

module mbxControlTb;
  import mbxPkg::*;

  localparam int NumTests = 12;
  localparam int CyclesPerTest = 40;

  typedef struct packed {
    cycleKindT kind;
    wordIdxT   addr;
    wordMaskT  valid;
    wordMaskT  needed;
  } stimT;

  logic      clk = 1'b0;
  logic      rst;
  logic      startCycle;
  cycleKindT cycleKind;
  wordIdxT   wordAddr;
  wordMaskT  wordValid;
  wordMaskT  wordNeeded;
  logic      ackPulse;
  logic      phaseChangeComing;
  wordMaskT  pendingWords;
  wordIdxT   sbusWord;
  logic      memRdRq;
  logic      memWrRq;
  logic      cacheToMbDone;
  int        errCount;
  integer    seed = 32'h257d;
  stimT      stim [NumTests];
  string     names [NumTests];

  always #50 clk = ~clk;

  mbxControl i_dut (
    .clk(clk), .rst(rst), .startCycle(startCycle), .cycleKind(cycleKind),
    .wordAddr(wordAddr), .wordValid(wordValid), .wordNeeded(wordNeeded),
    .ackPulse(ackPulse), .phaseChangeComing(phaseChangeComing),
    .pendingWords(pendingWords), .sbusWord(sbusWord), .memRdRq(memRdRq),
    .memWrRq(memWrRq), .cacheToMbDone(cacheToMbDone)
  );

  mbxChecker chk (
    .clk(clk), .rst(rst), .startCycle(startCycle), .cycleKind(cycleKind),
    .wordAddr(wordAddr), .wordValid(wordValid), .wordNeeded(wordNeeded),
    .ackPulse(ackPulse), .phaseChangeComing(phaseChangeComing),
    .pendingWords(pendingWords), .sbusWord(sbusWord), .memRdRq(memRdRq),
    .memWrRq(memWrRq), .cacheToMbDone(cacheToMbDone), .errCount(errCount)
  );

  task automatic setEntry(input int idx, input cycleKindT k, input wordIdxT a,
                          input wordMaskT v, input wordMaskT n, input string name);
    stim[idx].kind   = k;
    stim[idx].addr   = a;
    stim[idx].valid  = v;
    stim[idx].needed = n;
    names[idx]       = name;
  endtask

  task automatic fillRandom(input int idx, input string name);
    logic [31:0] rnd;
    rnd = $random(seed);
    setEntry(idx, cycleKindT'(rnd[2:0] % 3'd6), rnd[5:4], rnd[11:8], rnd[15:12], name);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One table entry with its start strobe followed by acks or writeback phases
  ////////////////////////////////////////////////////////////////////////////

  task automatic runEntry(input int idx);
    logic [31:0] rnd;
    @(negedge clk);
    startCycle = 1'b1;
    cycleKind  = stim[idx].kind;
    wordAddr   = stim[idx].addr;
    wordValid  = stim[idx].valid;
    wordNeeded = stim[idx].needed;
    @(negedge clk);
    startCycle = 1'b0;
    if (stim[idx].kind == kindWriteback) begin
      // Random phase changes stretch T2 while the acks are ignored
      while (pendingWords != '0 || (stim[idx].needed != '0 && !cacheToMbDone)) begin
        rnd = $random(seed);
        phaseChangeComing = rnd[0];
        ackPulse          = rnd[1];
        @(negedge clk);
      end
    end else begin
      while (pendingWords != '0) begin
        rnd = $random(seed);
        ackPulse = rnd[0];
        @(negedge clk);
      end
    end
    phaseChangeComing = 1'b0;
    // Stray ack on an empty mask
    ackPulse = 1'b1;
    @(negedge clk);
    ackPulse = 1'b0;
    @(negedge clk);
    @(posedge clk);
    chk.finishTest(names[idx]);
  endtask

  initial begin
    rst               = 1'b1;
    startCycle        = 1'b0;
    cycleKind         = kindIdle;
    wordAddr          = '0;
    wordValid         = '0;
    wordNeeded        = '0;
    ackPulse          = 1'b0;
    phaseChangeComing = 1'b0;
    setEntry(0, kindIdle, 2'd0, 4'b0000, 4'b1111, "idle loads nothing");
    setEntry(1, kindCoreRead, 2'd0, 4'b0101, 4'b1111, "core read of missing words");
    setEntry(2, kindOneWordRead, 2'd2, 4'b1111, 4'b0000, "one word read of word 2");
    setEntry(3, kindOneWordRead, 2'd3, 4'b0000, 4'b0001, "one word read of word 3");
    setEntry(4, kindPageRefill, 2'd1, 4'b0000, 4'b1111, "page refill of all words");
    setEntry(5, kindCoreRead, 2'd0, 4'b1111, 4'b1111, "core read with cache hit");
    setEntry(6, kindChanWrite, 2'd0, 4'b1111, 4'b1011, "channel write");
    setEntry(7, kindWriteback, 2'd0, 4'b0000, 4'b1111, "writeback of four words");
    setEntry(8, kindWriteback, 2'd0, 4'b1111, 4'b0110, "writeback of two words");
    setEntry(9, kindWriteback, 2'd0, 4'b0000, 4'b1000, "writeback of word 3");
    fillRandom(10, "random entry 1");
    fillRandom(11, "random entry 2");
    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    chk.finishTest("reset state");
    for (int i = 0; i < NumTests; i++) begin
      runEntry(i);
    end
    @(posedge clk);
    chk.reportTotals();
    if (errCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Budget per entry plus reset and tail cycles
  initial begin
    repeat (NumTests * CyclesPerTest + 10) @(posedge clk);
    $display("watchdog expired before all tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
